// File: build.f
+incdir+hw
+incdir+test
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/slot_extractor.sv
hw/group_buffer.sv
hw/flow_detector.sv
hw/pipeline_mux_top.sv
test/tb_pipeline_mux.sv

// File: test/tb_ref_model.svh
// Reference model of the mux stage and typed compare tasks, included inside the testbench module
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ==========================================================================
// Reference model
// ==========================================================================

// Padding instruction as decode expects it with every field other than the opcode zero
function automatic isa_pkg::instr_t exp_nop();
	isa_pkg::instr_t ins;
	ins = '0;
	ins.opcode = isa_pkg::OP_NOP;
	return ins;
endfunction

// Group held by the stage register straight out of reset
function automatic pipe_pkg::group_t reset_group();
	pipe_pkg::group_t g;
	for (int k = 0; k < `MUX_SLOTS; k++) begin
		g[k].pc = '0;
		g[k].ins = exp_nop();
		g[k].v = 1'b0;
		g[k].ssm = 1'b0;
	end
	return g;
endfunction

// Walks the parcels from the PC's parcel index
// Anything past the end of the line reads as a NOP parcel
function automatic logic [`MUX_LINE_BITS-1:0] align_line(input logic [`MUX_LINE_BITS-1:0] line,
	input logic [`MUX_PC_BITS-1:0] pc);
	logic [`MUX_LINE_BITS-1:0] res;
	int src;
	for (int p = 0; p < LINE_PARCELS; p++) begin
		src = p + int'(pc[5:1]);
		if (src < LINE_PARCELS)
			res[p*`MUX_PARCEL_BITS +: `MUX_PARCEL_BITS] =
				line[src*`MUX_PARCEL_BITS +: `MUX_PARCEL_BITS];
		else
			res[p*`MUX_PARCEL_BITS +: `MUX_PARCEL_BITS] = NOP_PARCEL;
	end
	return res;
endfunction

// First valid flow instruction in slot order decides the whole result
function automatic pipe_pkg::flow_t ref_flow(input pipe_pkg::group_t g);
	pipe_pkg::flow_t f;
	isa_pkg::opcode_e op;
	logic done;
	f = '0;
	f.tgt = `MUX_RST_PC;
	f.ret_pc = `MUX_RST_PC;
	done = 1'b0;
	for (int k = 0; k < `MUX_SLOTS; k++) begin
		op = g[k].ins.opcode;
		if (!done && g[k].v) begin
			if (op == isa_pkg::OP_BRA || op == isa_pkg::OP_BSR ||
				op == isa_pkg::OP_JMP || op == isa_pkg::OP_JSR) begin
				done = 1'b1;
				f.do_branch = 1'b1;
				// Displacement is a signed 26-bit byte offset
				f.tgt = g[k].pc + {{6{g[k].ins.disp[25]}}, g[k].ins.disp};
				f.do_call = (op == isa_pkg::OP_BSR) || (op == isa_pkg::OP_JSR);
			end else if (op == isa_pkg::OP_JSRR) begin
				done = 1'b1;
				f.do_call = 1'b1;
			end else if (op == isa_pkg::OP_RET) begin
				done = 1'b1;
				f.do_ret = 1'b1;
			end
			if (f.do_call)
				f.ret_pc = g[k].pc + `MUX_INS_BYTES;
		end
	end
	return f;
endfunction

// Expected registered group and flow for one set of inputs under the model history
function automatic void ref_stage(input stim_t s, input logic [`MUX_PC_BITS-1:0] prev_pc,
	input logic [`MUX_LINE_BITS-1:0] prev_line, input logic prev_ssm,
	output pipe_pkg::group_t g, output pipe_pkg::flow_t f);
	logic [`MUX_LINE_BITS-1:0] al;
	logic redundant;
	al = align_line(s.line, s.pc);
	redundant = (s.pc == prev_pc) && (al == prev_line);
	for (int k = 0; k < `MUX_SLOTS; k++) begin
		g[k].pc = s.pc + `MUX_PC_BITS'(k * `MUX_INS_BYTES);
		g[k].ins = isa_pkg::instr_t'(al[k*`MUX_INS_BITS +: `MUX_INS_BITS]);
		g[k].v = 1'b1;
		g[k].ssm = 1'b0;
		if (redundant) begin
			g[k].ins = exp_nop();
			g[k].v = 1'b0;
		end else if (s.ssm && (prev_ssm || k != 0)) begin
			g[k].ins = exp_nop();
			g[k].v = 1'b0;
			g[k].ssm = 1'b1;
		end
		if (s.irq || s.nmi || s.stomp)
			g[k].v = 1'b0;
		// Wrong-path slots are squashed as they enter the stage register
		if (s.branchmiss && g[k].pc < s.misspc) begin
			g[k].ins = exp_nop();
			g[k].v = 1'b0;
			g[k].ssm = 1'b0;
		end
	end
	f = ref_flow(g);
endfunction

// ==========================================================================
// Compare tasks
// ==========================================================================

task automatic check_group(input pipe_pkg::group_t got, input pipe_pkg::group_t exp);
	checks++;
	for (int k = 0; k < `MUX_SLOTS; k++) begin
		if (got[k] !== exp[k]) begin
			errors++;
			$display("[FAIL] %0t: slot %0d got %h/%h/%b/%b expected %h/%h/%b/%b (pc/ins/v/ssm)",
				$time, k, got[k].pc, got[k].ins, got[k].v, got[k].ssm,
				exp[k].pc, exp[k].ins, exp[k].v, exp[k].ssm);
		end
	end
endtask

task automatic check_flow(input pipe_pkg::flow_t got, input pipe_pkg::flow_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[FAIL] %0t: flow got %b%b%b %h %h expected %b%b%b %h %h (br call ret tgt ret_pc)",
			$time, got.do_branch, got.do_call, got.do_ret, got.tgt, got.ret_pc,
			exp.do_branch, exp.do_call, exp.do_ret, exp.tgt, exp.ret_pc);
	end
endtask

`endif

// File: test/tb_pipeline_mux.sv
// Testbench for the instruction mux stage, run with build.f and tb_pipeline_mux as top
`default_nettype none
`include "mux_macros.svh"

module tb_pipeline_mux;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int LINE_PARCELS = `MUX_LINE_BITS / `MUX_PARCEL_BITS;
	// Reset, then each test's driven cycles plus its closing idle cycle
	localparam int TEST_CYCLES = 4 + (40 + 1) + (4 + 1) + (6 + 1) + (9 + 1) + (6 + 1) + (8 + 1);
	localparam int MARGIN_CYCLES = 40;
	localparam logic [`MUX_PARCEL_BITS-1:0] NOP_PARCEL = `MUX_PARCEL_BITS'(isa_pkg::OP_NOP);
	localparam isa_pkg::opcode_e OPS [8] = '{isa_pkg::OP_NOP, isa_pkg::OP_ALU,
		isa_pkg::OP_BRA, isa_pkg::OP_BSR, isa_pkg::OP_JMP, isa_pkg::OP_JSR,
		isa_pkg::OP_JSRR, isa_pkg::OP_RET};

	// Every DUT input apart from clock and reset changes together each cycle
	typedef struct packed {
		logic [`MUX_LINE_BITS-1:0] line;
		logic [`MUX_PC_BITS-1:0]   pc;
		logic                      ssm;
		logic                      irq;
		logic                      nmi;
		logic                      stomp;
		logic                      branchmiss;
		logic [`MUX_PC_BITS-1:0]   misspc;
		logic                      en;
		logic                      stall;
	} stim_t;

	logic                      clk;
	logic                      rst_i;
	stim_t                     s;
	pipe_pkg::group_t          group_o;
	pipe_pkg::flow_t           flow_o;
	// Expectation for the inputs now on the pins and for the group the stage should hold
	pipe_pkg::group_t          nxt_group;
	pipe_pkg::flow_t           nxt_flow;
	logic [`MUX_LINE_BITS-1:0] nxt_line;
	pipe_pkg::group_t          cur_group;
	pipe_pkg::flow_t           cur_flow;
	// Model copy of the extractor history
	logic [`MUX_PC_BITS-1:0]   m_prev_pc;
	logic [`MUX_LINE_BITS-1:0] m_prev_line;
	logic                      m_prev_ssm;
	int                        seed = 28923;
	int                        checks = 0;
	int                        errors = 0;
	int                        test_checks0;
	int                        test_errors0;

	`include "tb_ref_model.svh"

	pipeline_mux_top DUT (
		.clk          (clk),
		.rst_i        (rst_i),
		.line_i       (s.line),
		.pc0_i        (s.pc),
		.ssm_i        (s.ssm),
		.irq_i        (s.irq),
		.nmi_i        (s.nmi),
		.stomp_i      (s.stomp),
		.branchmiss_i (s.branchmiss),
		.misspc_i     (s.misspc),
		.en_i         (s.en),
		.stall_i      (s.stall),
		.group_o      (group_o),
		.flow_o       (flow_o)
	);

	// ==========================================================================
	// Stimulus helpers
	// ==========================================================================

	function automatic stim_t idle_stim();
		stim_t st;
		st = '0;
		return st;
	endfunction

	// Random register fields and displacement with the opcode drawn from the enum
	function automatic isa_pkg::instr_t random_ins();
		logic [63:0] bits;
		isa_pkg::instr_t ins;
		bits = {$random(seed), $random(seed)};
		ins = isa_pkg::instr_t'(bits[47:0]);
		ins.opcode = OPS[bits[50:48]];
		return ins;
	endfunction

	function automatic stim_t random_stim();
		stim_t st;
		st = idle_stim();
		st.en = 1'b1;
		st.pc = $random(seed) & 32'h00FF_FFFE;
		for (int p = 0; p < LINE_PARCELS; p++)
			st.line[p*`MUX_PARCEL_BITS +: `MUX_PARCEL_BITS] = $random(seed);
		// Real instructions sit on the three-parcel grid that starts at the PC
		for (int p = int'(st.pc[5:1]); p + 2 < LINE_PARCELS; p += 3)
			st.line[p*`MUX_PARCEL_BITS +: `MUX_INS_BITS] = random_ins();
		return st;
	endfunction

	function automatic isa_pkg::instr_t mk_ins(input isa_pkg::opcode_e op, input int disp);
		isa_pkg::instr_t ins;
		ins = '0;
		ins.opcode = op;
		ins.disp = disp[25:0];
		return ins;
	endfunction

	// Directed group at a line-aligned PC with the rest of the line as NOP parcels
	function automatic stim_t group_stim(input logic [`MUX_PC_BITS-1:0] pc,
		input isa_pkg::instr_t i0, input isa_pkg::instr_t i1,
		input isa_pkg::instr_t i2, input isa_pkg::instr_t i3);
		stim_t st;
		st = idle_stim();
		st.en = 1'b1;
		st.pc = pc;
		st.line = {LINE_PARCELS{NOP_PARCEL}};
		st.line[4*`MUX_INS_BITS-1:0] = {i3, i2, i1, i0};
		return st;
	endfunction

	// One cycle of stimulus, placed just after the rising edge
	task automatic drive(input stim_t st);
		@(posedge clk);
		#2;
		s = st;
		ref_stage(st, m_prev_pc, m_prev_line, m_prev_ssm, nxt_group, nxt_flow);
		nxt_line = align_line(st.line, st.pc);
	endtask

	task automatic start_test();
		test_checks0 = checks;
		test_errors0 = errors;
	endtask

	// Idles the stage so the last group is compared before the line is printed
	task automatic end_test(input string name);
		drive(idle_stim());
		@(negedge clk);
		#1;
		$display("Test %-12s %0d checks, %0d errors", name,
			checks - test_checks0, errors - test_errors0);
	endtask

	// ==========================================================================
	// Clock, checker and watchdog
	// ==========================================================================

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Follows the stage register at each rising edge and compares at the falling edge
	initial begin
		cur_group = reset_group();
		cur_flow = ref_flow(cur_group);
		forever begin
			@(posedge clk);
			if (rst_i) begin
				cur_group = reset_group();
				cur_flow = ref_flow(cur_group);
				m_prev_pc = '0;
				m_prev_line = '0;
				m_prev_ssm = 1'b0;
			end else if (s.en && !s.stall) begin
				cur_group = nxt_group;
				cur_flow = nxt_flow;
				m_prev_pc = s.pc;
				m_prev_line = nxt_line;
				m_prev_ssm = s.ssm;
			end
			@(negedge clk);
			check_group(group_o, cur_group);
			check_flow(flow_o, cur_flow);
		end
	end

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles",
			TEST_CYCLES + MARGIN_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	// ==========================================================================
	// Test sequence
	// ==========================================================================

	initial begin
		stim_t st;
		s = idle_stim();
		nxt_group = reset_group();
		nxt_flow = ref_flow(nxt_group);
		nxt_line = '0;
		rst_i = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		rst_i = 1'b0;

		start_test();
		repeat (40) drive(random_stim());
		end_test("random");

		// The second copy of the same group is redundant while the third is not
		start_test();
		st = random_stim();
		drive(st);
		drive(st);
		drive(random_stim());
		drive(st);
		end_test("redundant");

		start_test();
		for (int i = 0; i < 6; i++) begin
			st = random_stim();
			st.ssm = (i < 4);
			drive(st);
		end
		end_test("single_step");

		// Each kill source alone, followed by a stall and a disable that must hold the stage
		start_test();
		for (int i = 0; i < 3; i++) begin
			st = random_stim();
			st.irq = (i == 0);
			st.nmi = (i == 1);
			st.stomp = (i == 2);
			drive(st);
		end
		drive(random_stim());
		for (int i = 0; i < 4; i++) begin
			st = random_stim();
			st.stall = (i < 3);
			st.en = (i != 3);
			drive(st);
		end
		drive(random_stim());
		end_test("kill_stall");

		// Miss address walks from slot 0 to past slot 3
		start_test();
		for (int i = 0; i < 6; i++) begin
			st = random_stim();
			st.branchmiss = 1'b1;
			st.misspc = st.pc + 5 * i;
			drive(st);
		end
		end_test("branch_miss");

		start_test();
		drive(group_stim(32'h1000, mk_ins(isa_pkg::OP_ALU, 0), mk_ins(isa_pkg::OP_BSR, 'h100),
			mk_ins(isa_pkg::OP_BRA, 'h20), mk_ins(isa_pkg::OP_RET, 0)));
		drive(group_stim(32'h1040, mk_ins(isa_pkg::OP_JSRR, 0), mk_ins(isa_pkg::OP_BRA, 8),
			mk_ins(isa_pkg::OP_ALU, 0), mk_ins(isa_pkg::OP_ALU, 0)));
		drive(group_stim(32'h1080, mk_ins(isa_pkg::OP_RET, 0), mk_ins(isa_pkg::OP_BSR, 'h40),
			mk_ins(isa_pkg::OP_ALU, 0), mk_ins(isa_pkg::OP_JSRR, 0)));
		drive(group_stim(32'h10C0, mk_ins(isa_pkg::OP_ALU, 0), mk_ins(isa_pkg::OP_ALU, 0),
			mk_ins(isa_pkg::OP_BRA, -'h80), mk_ins(isa_pkg::OP_RET, 0)));
		drive(group_stim(32'h1100, mk_ins(isa_pkg::OP_NOP, 0), mk_ins(isa_pkg::OP_ALU, 0),
			mk_ins(isa_pkg::OP_JSR, -4), mk_ins(isa_pkg::OP_JMP, 'h10)));
		drive(group_stim(32'h1140, mk_ins(isa_pkg::OP_ALU, 0), mk_ins(isa_pkg::OP_NOP, 0),
			mk_ins(isa_pkg::OP_ALU, 0), mk_ins(isa_pkg::OP_ALU, 0)));
		drive(group_stim(32'h1180, mk_ins(isa_pkg::OP_ALU, 0), mk_ins(isa_pkg::OP_ALU, 0),
			mk_ins(isa_pkg::OP_ALU, 0), mk_ins(isa_pkg::OP_JMP, 'h400)));
		// A squashed RET in slot 0 must not hide the branch behind it
		st = group_stim(32'h11C0, mk_ins(isa_pkg::OP_RET, 0), mk_ins(isa_pkg::OP_BRA, 8),
			mk_ins(isa_pkg::OP_ALU, 0), mk_ins(isa_pkg::OP_ALU, 0));
		st.branchmiss = 1'b1;
		st.misspc = 32'h11C2;
		drive(st);
		end_test("flow");

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/pipeline_mux_top.sv
// Top of the instruction mux stage joining extractor, stage register and flow detector
`default_nettype none
`include "mux_macros.svh"

module pipeline_mux_top (
	input  wire logic                       clk,
	input  wire logic                       rst_i,
	input  wire logic [`MUX_LINE_BITS-1:0]  line_i,
	input  wire logic [`MUX_PC_BITS-1:0]    pc0_i,
	input  wire logic                       ssm_i,
	input  wire logic                       irq_i,
	input  wire logic                       nmi_i,
	input  wire logic                       stomp_i,
	input  wire logic                       branchmiss_i,
	input  wire logic [`MUX_PC_BITS-1:0]    misspc_i,
	input  wire logic                       en_i,
	input  wire logic                       stall_i,
	output pipe_pkg::group_t                group_o,
	output pipe_pkg::flow_t                 flow_o
);

	logic             advance;
	pipe_pkg::group_t ext_group;

	// Stage moves only when enabled and decode is not back-pressuring
	assign advance = en_i && !stall_i;

	// ==========================================================================
	// Stage datapath
	// ==========================================================================

	slot_extractor u_extractor (
		.clk       (clk),
		.rst_i     (rst_i),
		.advance_i (advance),
		.line_i    (line_i),
		.pc0_i     (pc0_i),
		.ssm_i     (ssm_i),
		.irq_i     (irq_i),
		.nmi_i     (nmi_i),
		.stomp_i   (stomp_i),
		.group_o   (ext_group)
	);

	// Registered group is the stage output and also feeds flow detection
	group_buffer u_buffer (
		.clk          (clk),
		.rst_i        (rst_i),
		.advance_i    (advance),
		.branchmiss_i (branchmiss_i),
		.misspc_i     (misspc_i),
		.group_i      (ext_group),
		.group_o      (group_o)
	);

	flow_detector u_flow (
		.group_i (group_o),
		.flow_o  (flow_o)
	);

endmodule

`default_nettype wire

// File: hw/flow_detector.sv
// Scans the registered group for the first branch, call or return and reports target and return address
`default_nettype none
`include "mux_macros.svh"

module flow_detector (
	input  wire pipe_pkg::group_t  group_i,
	output pipe_pkg::flow_t        flow_o
);

	logic [`MUX_PC_BITS-1:0] slot_tgt [`MUX_SLOTS];
	logic [`MUX_PC_BITS-1:0] slot_ret [`MUX_SLOTS];
	logic                    found;
	pipe_pkg::flow_t         flow;

	// ==========================================================================
	// Per-slot addresses
	// ==========================================================================

	// Target is PC relative with the displacement sign-extended to a full
	// address, so backward branches wrap correctly
	// Return lands on the instruction right after the call
	always_comb begin
		for (int k = 0; k < `MUX_SLOTS; k++) begin
			slot_tgt[k] = group_i[k].pc
				+ `MUX_PC_BITS'(signed'(group_i[k].ins.disp));
			slot_ret[k] = group_i[k].pc + `MUX_PC_BITS'(`MUX_INS_BYTES);
		end
	end

	// ==========================================================================
	// Priority scan
	// ==========================================================================

	// Only the oldest flow instruction counts since anything after it is
	// on a path fetch has not chosen yet
	always_comb begin
		found = 1'b0;
		flow.do_branch = 1'b0;
		flow.do_call = 1'b0;
		flow.do_ret = 1'b0;
		flow.tgt = `MUX_RST_PC;
		flow.ret_pc = `MUX_RST_PC;

		for (int k = 0; k < `MUX_SLOTS; k++) begin
			// Invalid slots are skipped rather than stopping the scan
			if (!found && group_i[k].v) begin
				case (group_i[k].ins.opcode)
					isa_pkg::OP_BRA,
					isa_pkg::OP_JMP: begin
						found = 1'b1;
						flow.do_branch = 1'b1;
						flow.tgt = slot_tgt[k];
					end
					isa_pkg::OP_BSR,
					isa_pkg::OP_JSR: begin
						found = 1'b1;
						flow.do_branch = 1'b1;
						flow.do_call = 1'b1;
						flow.tgt = slot_tgt[k];
						flow.ret_pc = slot_ret[k];
					end
					isa_pkg::OP_JSRR: begin
						// Target comes from a register later in the pipe
						found = 1'b1;
						flow.do_call = 1'b1;
						flow.ret_pc = slot_ret[k];
					end
					isa_pkg::OP_RET: begin
						found = 1'b1;
						flow.do_ret = 1'b1;
					end
					default: begin
						found = 1'b0;
					end
				endcase
			end
		end
	end

	assign flow_o = flow;

endmodule

`default_nettype wire

// File: hw/group_buffer.sv
// Stage register for the instruction group, squashing slots that precede a pending branch-miss address
`default_nettype none
`include "mux_macros.svh"

module group_buffer (
	input  wire logic                     clk,
	input  wire logic                     rst_i,
	input  wire logic                     advance_i,
	input  wire logic                     branchmiss_i,
	input  wire logic [`MUX_PC_BITS-1:0]  misspc_i,
	input  wire pipe_pkg::group_t         group_i,
	output pipe_pkg::group_t              group_o
);

	pipe_pkg::group_t grp_d;

	// ==========================================================================
	// Branch-miss squash
	// ==========================================================================

	// Slots below the miss address belong to the wrong path and must not
	// reach decode
	// The address is kept so the slot still reads as part of the group
	always_comb begin
		for (int k = 0; k < `MUX_SLOTS; k++) begin
			grp_d[k] = group_i[k];
			if (branchmiss_i && (group_i[k].pc < misspc_i)) begin
				grp_d[k].ins = isa_pkg::nop_ins();
				grp_d[k].v = 1'b0;
				grp_d[k].ssm = 1'b0;
			end
		end
	end

	// ==========================================================================
	// Stage register
	// ==========================================================================

	// Comes out of reset as four invalid NOPs so the flow detector stays quiet
	// A stall simply holds the last group
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int k = 0; k < `MUX_SLOTS; k++) begin
				group_o[k].pc <= '0;
				group_o[k].ins <= isa_pkg::nop_ins();
				group_o[k].v <= 1'b0;
				group_o[k].ssm <= 1'b0;
			end
		end else if (advance_i) begin
			group_o <= grp_d;
		end
	end

endmodule

`default_nettype wire

// File: hw/slot_extractor.sv
// Aligns the fetched line on parcels and forms the combinational four-slot group for the stage register
`default_nettype none
`include "mux_macros.svh"

module slot_extractor (
	input  wire logic                       clk,
	input  wire logic                       rst_i,
	input  wire logic                       advance_i,
	input  wire logic [`MUX_LINE_BITS-1:0]  line_i,
	input  wire logic [`MUX_PC_BITS-1:0]    pc0_i,
	input  wire logic                       ssm_i,
	input  wire logic                       irq_i,
	input  wire logic                       nmi_i,
	input  wire logic                       stomp_i,
	output pipe_pkg::group_t                group_o
);

	localparam int LINE_PARCELS = `MUX_LINE_BITS / `MUX_PARCEL_BITS;

	// Padding parcel carries the NOP opcode in its low bits
	localparam logic [`MUX_PARCEL_BITS-1:0] NOP_PARCEL =
		`MUX_PARCEL_BITS'(isa_pkg::OP_NOP);

	logic [2*`MUX_LINE_BITS-1:0] padded_line;
	logic [2*`MUX_LINE_BITS-1:0] shifted_line;
	logic [`MUX_LINE_BITS-1:0]   aligned_line;
	logic [`MUX_LINE_BITS-1:0]   prev_aligned;
	logic [`MUX_PC_BITS-1:0]     prev_pc;
	logic                        prev_ssm;
	logic                        redundant;
	logic                        ssm_first;
	logic                        kill;
	pipe_pkg::group_t            grp;

	// ==========================================================================
	// Line alignment
	// ==========================================================================

	// PC bits 5 to 1 pick the starting parcel within the 64-byte line
	// Parcels shifted in from above the line read as NOPs
	always_comb begin
		padded_line = {{LINE_PARCELS{NOP_PARCEL}}, line_i};
		shifted_line = padded_line >> (int'(pc0_i[5:1]) * `MUX_PARCEL_BITS);
		aligned_line = shifted_line[`MUX_LINE_BITS-1:0];
	end

	// ==========================================================================
	// Group control
	// ==========================================================================

	always_comb begin
		// Fetch repeated the last group, so nothing new is in it
		redundant = (pc0_i == prev_pc) && (aligned_line == prev_aligned);
		// First cycle of single-step still lets one instruction through
		ssm_first = ssm_i && !prev_ssm;
		// Interrupts and a stomp throw the whole group away
		kill = irq_i || nmi_i || stomp_i;
	end

	// ==========================================================================
	// Slot formation
	// ==========================================================================

	always_comb begin
		for (int k = 0; k < `MUX_SLOTS; k++) begin
			// Each slot sits one instruction size past the previous one
			grp[k].pc = pc0_i + `MUX_PC_BITS'(k * `MUX_INS_BYTES);
			grp[k].ins = isa_pkg::instr_t'(aligned_line[k*`MUX_INS_BITS +: `MUX_INS_BITS]);
			grp[k].v = 1'b1;
			grp[k].ssm = 1'b0;

			if (redundant) begin
				grp[k].ins = isa_pkg::nop_ins();
				grp[k].v = 1'b0;
			end else if (ssm_i && !(ssm_first && k == 0)) begin
				// Slot 0 survives only on the rising edge of single-step
				grp[k].ins = isa_pkg::nop_ins();
				grp[k].v = 1'b0;
				grp[k].ssm = 1'b1;
			end

			// Addresses stay intact so the buffer can still compare them
			if (kill) begin
				grp[k].v = 1'b0;
			end
		end
	end

	assign group_o = grp;

	// ==========================================================================
	// History of the last accepted group
	// ==========================================================================

	// Only updated when the buffer takes the group, so a stall keeps the
	// comparison against what decode last received
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_pc <= '0;
			prev_aligned <= '0;
			prev_ssm <= 1'b0;
		end else if (advance_i) begin
			prev_pc <= pc0_i;
			prev_aligned <= aligned_line;
			prev_ssm <= ssm_i;
		end
	end

endmodule

`default_nettype wire

// File: hw/pipe_pkg.sv
// Slot, group and flow-result types passed between the extractor, buffer and detector
`default_nettype none
`include "mux_macros.svh"

package pipe_pkg;

	// ==========================================================================
	// Instruction slot
	// ==========================================================================

	// One instruction with its own byte address
	// v marks a slot that decode may execute
	// ssm marks a slot that single-step mode has removed from the group
	typedef struct packed {
		logic [`MUX_PC_BITS-1:0] pc;
		isa_pkg::instr_t         ins;
		logic                    v;
		logic                    ssm;
	} slot_t;

	// Group of slots in program order, index 0 is the oldest instruction
	typedef slot_t [0:`MUX_SLOTS-1] group_t;

	// ==========================================================================
	// Flow detection result
	// ==========================================================================

	// Strobes describe the first flow instruction found in the group
	// do_branch covers BRA, BSR, JMP and JSR, which all carry a direct target
	// do_call is also set by JSRR, which has no target here
	// tgt and ret_pc fall back to the reset address when unused
	typedef struct packed {
		logic                    do_branch;
		logic                    do_call;
		logic                    do_ret;
		logic [`MUX_PC_BITS-1:0] tgt;
		logic [`MUX_PC_BITS-1:0] ret_pc;
	} flow_t;

endpackage

`default_nettype wire

// File: hw/isa_pkg.sv
// Opcode encoding and instruction field layout, referenced by scoped name from the mux stage
`default_nettype none
`include "mux_macros.svh"

package isa_pkg;

	// Seven-bit major opcode in the low bits of the first parcel
	// OP_NOP is also what the extractor pads past the end of the line with
	typedef enum logic [6:0] {
		OP_NOP  = 7'h01,
		OP_ALU  = 7'h04,
		// Direct branches and calls, target is PC relative
		OP_BRA  = 7'h20,
		OP_BSR  = 7'h21,
		OP_JMP  = 7'h22,
		OP_JSR  = 7'h23,
		// Register call has no target known at fetch time
		OP_JSRR = 7'h24,
		OP_RET  = 7'h25
	} opcode_e;

	// Fields from the top of the 48-bit word down
	// The displacement is a signed byte offset from the instruction address
	typedef struct packed {
		logic [25:0] disp;
		logic [4:0]  rs2;
		logic [4:0]  rs1;
		logic [4:0]  rd;
		opcode_e     opcode;
	} instr_t;

	// Canonical NOP with every register field zero
	function automatic instr_t nop_ins();
		instr_t ins;
		ins = '0;
		ins.opcode = OP_NOP;
		return ins;
	endfunction

endpackage

`default_nettype wire

// File: hw/mux_macros.svh
// Width, slot and address macros for the instruction mux stage, included by every file that sizes a bus
`ifndef MUX_MACROS_SVH
`define MUX_MACROS_SVH

// ==========================================================================
// Line and address geometry
// ==========================================================================

// One fetched cache line as delivered by the instruction cache
`define MUX_LINE_BITS 512

// Byte address width of the fetch PC
`define MUX_PC_BITS 32

// Instructions are aligned on 16-bit parcels within the line
`define MUX_PARCEL_BITS 16

// ==========================================================================
// Instruction group shape
// ==========================================================================

// Every instruction is three parcels long
`define MUX_INS_BITS 48
`define MUX_INS_BYTES 6

// Number of slots handed to decode each cycle
`define MUX_SLOTS 4

// Address reported for target and return when no flow instruction is seen
`define MUX_RST_PC 32'hFFFD_0000

`endif
